// File: common/mem_cfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// number of word-interleaved ram banks
`define MEM_NUM_BANKS 4

// word address bits inside one bank
`define MEM_BANK_BITS 8

// top address byte of the uart window
`define MEM_UART_BASE 8'h7F

// entries per uart byte fifo
`define UART_FIFO_DEPTH 4

`endif

// File: common/isa_pkg.sv
`default_nettype none

package isa_pkg;

   // data word and byte address
   typedef logic [31:0] word_t;
   typedef logic [31:0] addr_t;

   // memory operations seen by the stage
   typedef enum logic [2:0] {
      OP_NONE,
      OP_LW,
      OP_FLW,
      OP_SW,
      OP_FSW,
      OP_LBU,
      OP_SB
   } mem_op_t;

endpackage

`default_nettype wire

// File: common/mem_pkg.sv
`default_nettype none

`include "mem_cfg.svh"

package mem_pkg;

   localparam int BANK_SEL_W = $clog2(`MEM_NUM_BANKS);

   typedef logic [BANK_SEL_W-1:0] bank_sel_t;
   typedef logic [`MEM_BANK_BITS-1:0] bank_addr_t;

   // axi-lite response codes
   typedef logic [1:0] axi_resp_t;
   localparam axi_resp_t AXI_OKAY = 2'b00;
   localparam axi_resp_t AXI_SLVERR = 2'b10;

   typedef enum logic [1:0] {
      WAITING_REQ,
      PROCESSING_UART,
      PROCESSING_MEM1,
      PROCESSING_MEM2
   } mem_state_t;

endpackage

`default_nettype wire

// File: mem_stage/mem_stage.sv
`default_nettype none

`include "mem_cfg.svh"

module mem_stage import isa_pkg::*, mem_pkg::*; (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      enabled,
   input  mem_op_t                   op,
   input  addr_t                     addr,
   input  word_t                     rs2,
   input  word_t                     frs2,
   input  word_t                     rdata_ram,
   input  logic                      awready,
   input  logic                      wready,
   input  axi_resp_t                 bresp,
   input  logic                      bvalid,
   input  logic                      arready,
   input  word_t                     rdata_axi,
   input  axi_resp_t                 rresp,
   input  logic                      rvalid,
   output logic [`MEM_NUM_BANKS-1:0] bank_en,
   output bank_addr_t                bank_addr,
   output word_t                     bank_din,
   output logic [3:0]                bank_we,
   output bank_sel_t                 read_sel,
   output addr_t                     awaddr,
   output logic                      awvalid,
   output word_t                     wdata,
   output logic [3:0]                wstrb,
   output logic                      wvalid,
   output logic                      bready,
   output addr_t                     araddr,
   output logic                      arvalid,
   output logic                      rready,
   output logic                      completed,
   output word_t                     result
);

   localparam int NUM_BANKS = `MEM_NUM_BANKS;
   localparam int SEL_HI = BANK_SEL_W + 1;
   localparam int BADDR_HI = BANK_SEL_W + `MEM_BANK_BITS + 1;

   mem_state_t state;
   mem_op_t op_q;
   logic completed_q;

   logic is_load;
   logic is_store;
   logic uart_hit;
   logic st_q;
   logic aw_done;
   logic w_done;
   word_t store_data;
   addr_t uart_off;
   bank_sel_t ram_sel;

   // request decode
   assign is_load = op inside {OP_LW, OP_FLW, OP_LBU};
   assign is_store = op inside {OP_SW, OP_FSW, OP_SB};
   assign uart_hit = (addr[31:24] == `MEM_UART_BASE);
   assign store_data = (op == OP_FSW) ? frs2 : rs2;
   assign uart_off = {28'b0, addr[3:0]};
   assign ram_sel = addr[SEL_HI:2];

   assign st_q = op_q inside {OP_SW, OP_FSW, OP_SB};

   // channel counts as done once its transfer happens
   assign aw_done = !awvalid || awready;
   assign w_done = !wvalid || wready;

   // result is only offered once the request is withdrawn
   assign completed = completed_q & ~enabled;

   always_ff @(posedge clk) begin
      if (rstn) begin
         state <= WAITING_REQ;
         completed_q <= 1'b0;
         bank_en <= '0;
         bank_we <= '0;
         awvalid <= 1'b0;
         wvalid <= 1'b0;
         bready <= 1'b0;
         arvalid <= 1'b0;
         rready <= 1'b0;
      end else begin
         case (state)
            WAITING_REQ: begin
               if (enabled) begin
                  op_q <= op;
                  result <= addr;
                  if (!(is_load || is_store)) begin
                     // alu result passes straight through
                     completed_q <= 1'b1;
                  end else if (uart_hit) begin
                     completed_q <= 1'b0;
                     state <= PROCESSING_UART;
                     if (is_store) begin
                        awaddr <= uart_off;
                        awvalid <= 1'b1;
                        wdata <= {24'b0, store_data[7:0]};
                        wstrb <= 4'b0001;
                        wvalid <= 1'b1;
                     end else begin
                        araddr <= uart_off;
                        arvalid <= 1'b1;
                     end
                  end else begin
                     completed_q <= 1'b0;
                     state <= PROCESSING_MEM1;
                     bank_en <= NUM_BANKS'(1) << ram_sel;
                     bank_addr <= addr[BADDR_HI:SEL_HI+1];
                     read_sel <= ram_sel;
                     bank_din <= store_data;
                     bank_we <= is_store ? 4'b1111 : 4'b0000;
                  end
               end
            end
            PROCESSING_UART: begin
               if (st_q) begin
                  if (awvalid && awready) begin
                     awvalid <= 1'b0;
                  end
                  if (wvalid && wready) begin
                     wvalid <= 1'b0;
                  end
                  if (bready && bvalid) begin
                     bready <= 1'b0;
                     state <= WAITING_REQ;
                     completed_q <= 1'b1;
                     // error response clears result
                     if (bresp != AXI_OKAY) begin
                        result <= '0;
                     end
                  end else if (aw_done && w_done) begin
                     bready <= 1'b1;
                  end
               end else begin
                  if (arvalid && arready) begin
                     arvalid <= 1'b0;
                     rready <= 1'b1;
                  end
                  if (rvalid && rready) begin
                     rready <= 1'b0;
                     state <= WAITING_REQ;
                     completed_q <= 1'b1;
                     result <= (rresp == AXI_OKAY) ? {24'b0, rdata_axi[7:0]} : '0;
                  end
               end
            end
            PROCESSING_MEM1: begin
               // bank acts on this edge
               bank_en <= '0;
               bank_we <= '0;
               state <= PROCESSING_MEM2;
            end
            PROCESSING_MEM2: begin
               state <= WAITING_REQ;
               completed_q <= 1'b1;
               if (!st_q) begin
                  result <= rdata_ram;
               end
            end
            default: begin
               state <= WAITING_REQ;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/ram_bank.sv
`default_nettype none

`include "mem_cfg.svh"

module ram_bank import isa_pkg::*, mem_pkg::*; (
   input  logic       clk,
   input  logic       en,
   input  logic [3:0] we,
   input  bank_addr_t addr,
   input  word_t      din,
   output word_t      dout
);

   localparam int DEPTH = 2 ** `MEM_BANK_BITS;

   word_t mem [DEPTH];

   // read-first, dout shows the old word on a write
   always_ff @(posedge clk) begin
      if (en) begin
         for (int i = 0; i < 4; i++) begin
            if (we[i]) begin
               mem[addr][8*i +: 8] <= din[8*i +: 8];
            end
         end
         dout <= mem[addr];
      end
   end

endmodule

`default_nettype wire

// File: logic/bank_collector.sv
`default_nettype none

`include "mem_cfg.svh"

module bank_collector import isa_pkg::*, mem_pkg::*; (
   input  logic      clk,
   input  logic      rstn,
   input  logic      capture,
   input  bank_sel_t read_sel,
   input  word_t     bank_dout [`MEM_NUM_BANKS],
   output word_t     rdata
);

   bank_sel_t sel_q;

   // index of the bank whose read is in flight
   always_ff @(posedge clk) begin
      if (rstn) begin
         sel_q <= '0;
      end else if (capture) begin
         sel_q <= read_sel;
      end
   end

   assign rdata = bank_dout[sel_q];

endmodule

`default_nettype wire

// File: logic/uart_axi_regs.sv
`default_nettype none

`include "mem_cfg.svh"

module uart_axi_regs import isa_pkg::*, mem_pkg::*; (
   input  logic       clk,
   input  logic       rstn,
   input  addr_t      awaddr,
   input  logic       awvalid,
   output logic       awready,
   input  word_t      wdata,
   input  logic [3:0] wstrb,
   input  logic       wvalid,
   output logic       wready,
   output axi_resp_t  bresp,
   output logic       bvalid,
   input  logic       bready,
   input  addr_t      araddr,
   input  logic       arvalid,
   output logic       arready,
   output word_t      rdata,
   output axi_resp_t  rresp,
   output logic       rvalid,
   input  logic       rready,
   input  logic [7:0] rx_byte,
   input  logic       rx_strobe,
   input  logic       tx_ready,
   output logic [7:0] tx_byte,
   output logic       tx_strobe
);

   localparam int DEPTH = `UART_FIFO_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [7:0] rx_mem [DEPTH];
   logic [7:0] tx_mem [DEPTH];
   logic [PTR_W-1:0] rx_wr_ptr, rx_rd_ptr, tx_wr_ptr, tx_rd_ptr;
   logic [CNT_W-1:0] rx_count, tx_count;

   logic rx_empty, tx_full, tx_empty;
   logic rx_push, rx_pop, tx_push, tx_pop;
   logic wr_is_tx, wr_ok, wr_fire, rd_fire;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign rx_empty = (rx_count == '0);
   assign tx_empty = (tx_count == '0);
   assign tx_full = (tx_count == CNT_W'(DEPTH));

   // aw and w are taken together, tx writes wait for room
   assign wr_is_tx = (awaddr[3:0] == 4'h8);
   assign wr_ok = !wr_is_tx || !tx_full;
   assign awready = awvalid && wvalid && !bvalid && wr_ok;
   assign wready = awready;
   assign wr_fire = awvalid && awready;

   assign arready = arvalid && !rvalid;
   assign rd_fire = arvalid && arready;

   assign rx_push = rx_strobe && !rx_empty ? rx_count != CNT_W'(DEPTH) : rx_strobe;
   assign rx_pop = rd_fire && (araddr[3:0] == 4'h0) && !rx_empty;
   assign tx_push = wr_fire && wr_is_tx && wstrb[0];
   assign tx_pop = tx_ready && !tx_empty;

   assign tx_strobe = tx_pop;
   assign tx_byte = tx_mem[tx_rd_ptr];

   always_ff @(posedge clk) begin
      if (rx_push) begin
         rx_mem[rx_wr_ptr] <= rx_byte;
      end
      if (tx_push) begin
         tx_mem[tx_wr_ptr] <= wdata[7:0];
      end
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         rx_wr_ptr <= '0;
         rx_rd_ptr <= '0;
         rx_count <= '0;
         tx_wr_ptr <= '0;
         tx_rd_ptr <= '0;
         tx_count <= '0;
      end else begin
         if (rx_push) rx_wr_ptr <= next_ptr(rx_wr_ptr);
         if (rx_pop) rx_rd_ptr <= next_ptr(rx_rd_ptr);
         if (tx_push) tx_wr_ptr <= next_ptr(tx_wr_ptr);
         if (tx_pop) tx_rd_ptr <= next_ptr(tx_rd_ptr);
         rx_count <= rx_count + CNT_W'(rx_push) - CNT_W'(rx_pop);
         tx_count <= tx_count + CNT_W'(tx_push) - CNT_W'(tx_pop);
      end
   end

   // write response
   always_ff @(posedge clk) begin
      if (rstn) begin
         bvalid <= 1'b0;
      end else if (wr_fire) begin
         bvalid <= 1'b1;
         bresp <= wr_is_tx ? AXI_OKAY : AXI_SLVERR;
      end else if (bvalid && bready) begin
         bvalid <= 1'b0;
      end
   end

   // read data, one cycle after the address
   always_ff @(posedge clk) begin
      if (rstn) begin
         rvalid <= 1'b0;
      end else if (rd_fire) begin
         rvalid <= 1'b1;
         case (araddr[3:0])
            4'h0: begin
               rdata <= rx_empty ? '0 : {24'b0, rx_mem[rx_rd_ptr]};
               rresp <= rx_empty ? AXI_SLVERR : AXI_OKAY;
            end
            4'h4: begin
               rdata <= {30'b0, tx_full, !rx_empty};
               rresp <= AXI_OKAY;
            end
            default: begin
               rdata <= '0;
               rresp <= AXI_SLVERR;
            end
         endcase
      end else if (rvalid && rready) begin
         rvalid <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: logic/mem_subsystem.sv
`default_nettype none

`include "mem_cfg.svh"

module mem_subsystem import isa_pkg::*, mem_pkg::*; (
   input  logic       clk,
   input  logic       rstn,
   input  logic       enabled,
   input  mem_op_t    op,
   input  addr_t      addr,
   input  word_t      rs2,
   input  word_t      frs2,
   input  logic [7:0] rx_byte,
   input  logic       rx_strobe,
   input  logic       tx_ready,
   output logic       completed,
   output word_t      result,
   output logic [7:0] tx_byte,
   output logic       tx_strobe
);

   logic [`MEM_NUM_BANKS-1:0] bank_en;
   bank_addr_t bank_addr;
   word_t bank_din;
   logic [3:0] bank_we;
   bank_sel_t read_sel;
   word_t bank_dout [`MEM_NUM_BANKS];
   word_t rdata_ram;
   logic capture;

   addr_t awaddr, araddr;
   word_t wdata, rdata_axi;
   logic [3:0] wstrb;
   axi_resp_t bresp, rresp;
   logic awvalid, awready, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rvalid, rready;

   // any bank enabled means a read is launched
   assign capture = |bank_en;

   mem_stage i_mem_stage (
      .clk, .rstn, .enabled, .op, .addr, .rs2, .frs2, .rdata_ram,
      .awready, .wready, .bresp, .bvalid, .arready, .rdata_axi, .rresp, .rvalid,
      .bank_en, .bank_addr, .bank_din, .bank_we, .read_sel,
      .awaddr, .awvalid, .wdata, .wstrb, .wvalid, .bready, .araddr, .arvalid, .rready,
      .completed, .result
   );

   for (genvar b = 0; b < `MEM_NUM_BANKS; b++) begin : g_bank
      ram_bank i_ram_bank (
         .clk  (clk),
         .en   (bank_en[b]),
         .we   (bank_we),
         .addr (bank_addr),
         .din  (bank_din),
         .dout (bank_dout[b])
      );
   end

   bank_collector i_bank_collector (
      .clk, .rstn, .capture, .read_sel, .bank_dout,
      .rdata (rdata_ram)
   );

   uart_axi_regs i_uart_axi_regs (
      .clk, .rstn,
      .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
      .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
      .rdata (rdata_axi), .rresp, .rvalid, .rready,
      .rx_byte, .rx_strobe, .tx_ready, .tx_byte, .tx_strobe
   );

endmodule

`default_nettype wire

// File: testbench/mem_subsystem_chk.sv
`default_nettype none

`include "mem_cfg.svh"

module mem_subsystem_chk import mem_pkg::*; (
   input logic                      clk,
   input logic                      rstn,
   input logic                      enabled,
   input logic                      completed,
   input mem_state_t                state,
   input logic [`MEM_NUM_BANKS-1:0] bank_en,
   input logic                      awvalid,
   input logic                      awready,
   input logic                      wvalid,
   input logic                      wready,
   input logic                      bvalid,
   input logic                      bready,
   input logic                      arvalid,
   input logic                      arready,
   input logic                      rvalid,
   input logic                      rready
);

   timeunit 1ns;
   timeprecision 100ps;

   // valid holds until its transfer
   aw_hold: assert property (@(posedge clk) disable iff (rstn)
      awvalid && !awready |=> awvalid)
      else $error("awvalid dropped before awready");

   w_hold: assert property (@(posedge clk) disable iff (rstn)
      wvalid && !wready |=> wvalid)
      else $error("wvalid dropped before wready");

   b_hold: assert property (@(posedge clk) disable iff (rstn)
      bvalid && !bready |=> bvalid)
      else $error("bvalid dropped before bready");

   ar_hold: assert property (@(posedge clk) disable iff (rstn)
      arvalid && !arready |=> arvalid)
      else $error("arvalid dropped before arready");

   r_hold: assert property (@(posedge clk) disable iff (rstn)
      rvalid && !rready |=> rvalid)
      else $error("rvalid dropped before rready");

   // idle stage with no request must not complete
   idle_complete: assert property (@(posedge clk) disable iff (rstn)
      state == WAITING_REQ && $past(state) == WAITING_REQ && !$past(enabled)
      |-> !$rose(completed))
      else $error("completed rose without a request");

   // one bank at most, and only in the first ram cycle
   bank_onehot: assert property (@(posedge clk) disable iff (rstn)
      $onehot0(bank_en) && ((bank_en != '0) == (state == PROCESSING_MEM1)))
      else $error("bank_en not one-hot or active outside the bank access");

endmodule

bind mem_stage mem_subsystem_chk i_chk (
   .clk       (clk),
   .rstn      (rstn),
   .enabled   (enabled),
   .completed (completed),
   .state     (state),
   .bank_en   (bank_en),
   .awvalid   (awvalid),
   .awready   (awready),
   .wvalid    (wvalid),
   .wready    (wready),
   .bvalid    (bvalid),
   .bready    (bready),
   .arvalid   (arvalid),
   .arready   (arready),
   .rvalid    (rvalid),
   .rready    (rready)
);

`default_nettype wire

// File: testbench/mem_subsystem_tb.sv
`default_nettype none

module mem_subsystem_tb import isa_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int FIELDS = 8;
   localparam int MAX_PAT = 64;
   localparam int RESET_CYCLES = 5;
   localparam int REQ_LIMIT = 40;
   localparam int STALL_CYCLES = 10;
   localparam int DRAIN_CYCLES = 20;
   localparam word_t NO_BYTE = 32'h100;

   logic clk;
   logic rstn;
   logic enabled;
   mem_op_t op;
   addr_t addr;
   word_t rs2;
   word_t frs2;
   logic [7:0] rx_byte;
   logic rx_strobe;
   logic tx_ready;
   logic completed;
   word_t result;
   logic [7:0] tx_byte;
   logic tx_strobe;

   word_t pat [FIELDS*MAX_PAT];
   logic [7:0] tx_expect [$];
   int num_pat;
   int errors;
   int passed;
   int failed;
   int cycle_count;
   int timeout_limit;

   mem_subsystem i_dut (
      .clk, .rstn, .enabled, .op, .addr, .rs2, .frs2,
      .rx_byte, .rx_strobe, .tx_ready,
      .completed, .result, .tx_byte, .tx_strobe
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // cycles from sampling to completion, 0 where the latency varies
   function automatic int expected_latency(input word_t f_op, input word_t f_addr);
      if (f_op == 0) begin
         return 1;
      end
      if (f_addr[31:24] == 8'h7F) begin
         return 0;
      end
      return 3;
   endfunction

   task automatic pulse_reset();
      @(posedge clk);
      #2 rstn = 1'b1;
      repeat (2) @(posedge clk);
      #2 rstn = 1'b0;
   endtask

   task automatic inject_rx(input logic [7:0] b);
      @(posedge clk);
      #2 rx_byte = b;
      rx_strobe = 1'b1;
      @(posedge clk);
      #2 rx_strobe = 1'b0;
   endtask

   task automatic run_test(input int n);
      word_t f_op, f_addr, f_rs2, f_frs2, f_exp, f_rx, f_mode, f_tx;
      int latency;
      int exp_lat;
      int gap;
      logic ok;
      string name;
      f_op = pat[n*FIELDS];
      f_addr = pat[n*FIELDS+1];
      f_rs2 = pat[n*FIELDS+2];
      f_frs2 = pat[n*FIELDS+3];
      f_exp = pat[n*FIELDS+4];
      f_rx = pat[n*FIELDS+5];
      f_mode = pat[n*FIELDS+6];
      f_tx = pat[n*FIELDS+7];
      name = $sformatf("test_%0d", n);
      ok = 1'b1;
      exp_lat = expected_latency(f_op, f_addr);

      if (f_mode == 3) begin
         pulse_reset();
         assert (completed == 1'b0) else begin
            $display("%s: completed still high after reset", name);
            ok = 1'b0;
         end
      end
      if (f_rx != NO_BYTE) begin
         inject_rx(f_rx[7:0]);
      end
      // ram stores go back to back
      gap = (exp_lat == 3 && f_op inside {3, 4}) ? 0 : $urandom % 3;
      repeat (gap) @(posedge clk);

      @(posedge clk);
      #2 tx_ready = (f_mode == 1 || f_mode == 3);
      if (f_tx != NO_BYTE) begin
         tx_expect.push_back(f_tx[7:0]);
      end
      enabled = 1'b1;
      op = mem_op_t'(f_op[2:0]);
      addr = f_addr;
      rs2 = f_rs2;
      frs2 = f_frs2;
      @(posedge clk);
      #2 enabled = 1'b0;
      latency = 1;

      // back-pressure case, sb must wait for room in the tx FIFO
      if (f_mode == 2) begin
         for (int k = 0; k < STALL_CYCLES; k++) begin
            @(negedge clk);
            assert (!completed) else begin
               $display("%s: store completed while the tx FIFO was full", name);
               ok = 1'b0;
            end
            @(posedge clk);
            latency++;
         end
         #2 tx_ready = 1'b1;
      end

      @(negedge clk);
      while (!completed && latency < REQ_LIMIT + STALL_CYCLES) begin
         @(posedge clk);
         latency++;
         @(negedge clk);
      end

      assert (completed) else begin
         $display("%s: request never completed", name);
         ok = 1'b0;
      end
      if (completed) begin
         assert (result == f_exp) else begin
            $display("Fail %s: expected %h, actual %h", name, f_exp, result);
            ok = 1'b0;
         end
         if (exp_lat != 0) begin
            assert (latency == exp_lat) else begin
               $display("Fail %s latency: expected %0d, actual %0d", name, exp_lat,
                        latency);
               ok = 1'b0;
            end
         end
      end

      if (ok) begin
         $display("pass %s op %0d addr %h", name, f_op, f_addr);
         passed++;
      end else begin
         $display("%s failed", name);
         failed++;
         errors++;
      end
   endtask

   // bytes leaving the tx FIFO in order
   always @(posedge clk) begin
      if (!rstn && tx_strobe) begin
         if (tx_expect.size() == 0) begin
            $display("tx byte %h appeared with none expected", tx_byte);
            errors++;
         end else begin
            assert (tx_byte == tx_expect[0]) else begin
               $display("Fail tx_byte: expected %h, actual %h", tx_expect[0], tx_byte);
               errors++;
            end
            tx_expect.pop_front();
         end
      end
   end

   initial begin
      cycle_count = 0;
      wait (timeout_limit > 0);
      while (cycle_count <= timeout_limit) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: run did not end within %0d cycles", timeout_limit);
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      int drain;
      void'($urandom(32'he8764c43));
      rstn = 1'b1;
      enabled = 1'b0;
      op = OP_NONE;
      addr = '0;
      rs2 = '0;
      frs2 = '0;
      rx_byte = '0;
      rx_strobe = 1'b0;
      tx_ready = 1'b1;
      errors = 0;
      passed = 0;
      failed = 0;
      timeout_limit = 0;
      for (int i = 0; i < FIELDS*MAX_PAT; i++) begin
         pat[i] = '1;
      end
      $readmemh("testbench/mem_patterns.txt", pat);
      num_pat = 0;
      while (num_pat < MAX_PAT && pat[num_pat*FIELDS] != '1) begin
         num_pat++;
      end
      timeout_limit = num_pat * 40 + RESET_CYCLES;

      repeat (RESET_CYCLES) @(posedge clk);
      #2 rstn = 1'b0;

      for (int n = 0; n < num_pat; n++) begin
         run_test(n);
      end

      drain = 0;
      while (tx_expect.size() != 0 && drain < DRAIN_CYCLES) begin
         @(posedge clk);
         drain++;
      end
      if (tx_expect.size() != 0) begin
         $display("%0d expected tx bytes never appeared", tx_expect.size());
         errors++;
      end

      $display("tests %0d, passed %0d, failed %0d, errors %0d", num_pat, passed, failed,
               errors);
      if (errors == 0 && num_pat > 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+common
common/isa_pkg.sv
common/mem_pkg.sv
mem_stage/mem_stage.sv
logic/ram_bank.sv
logic/bank_collector.sv
logic/uart_axi_regs.sv
logic/mem_subsystem.sv
testbench/mem_subsystem_chk.sv
testbench/mem_subsystem_tb.sv

// File: testbench/mem_patterns.txt
// op addr rs2 frs2 expected_result rx_byte(100=none) tx_mode expected_tx(100=none)
// tx_mode: 0 tx_ready low, 1 high, 2 stall then raise, 3 reset pulse first
00000000 00001234 00000000 00000000 00001234 00000100 00000001 00000100
00000000 DEADBEEC 00000000 00000000 DEADBEEC 00000100 00000001 00000100
00000003 00000100 11111111 00000000 00000100 00000100 00000001 00000100
00000004 00000104 00000000 22222222 00000104 00000100 00000001 00000100
00000003 00000108 33333333 00000000 00000108 00000100 00000001 00000100
00000004 0000010C 00000000 44444444 0000010C 00000100 00000001 00000100
00000001 00000100 00000000 00000000 11111111 00000100 00000001 00000100
00000002 00000104 00000000 00000000 22222222 00000100 00000001 00000100
00000001 00000108 00000000 00000000 33333333 00000100 00000001 00000100
00000002 0000010C 00000000 00000000 44444444 00000100 00000001 00000100
00000006 7F000008 000000A5 00000000 7F000008 00000100 00000001 000000A5
00000005 7F000004 00000000 00000000 00000000 00000100 00000001 00000100
00000005 7F000004 00000000 00000000 00000001 0000003C 00000001 00000100
00000005 7F000000 00000000 00000000 0000003C 00000100 00000001 00000100
00000005 7F000000 00000000 00000000 00000000 00000100 00000001 00000100
00000006 7F000008 00000001 00000000 7F000008 00000100 00000000 00000001
00000006 7F000008 00000002 00000000 7F000008 00000100 00000000 00000002
00000006 7F000008 00000003 00000000 7F000008 00000100 00000000 00000003
00000006 7F000008 00000004 00000000 7F000008 00000100 00000000 00000004
00000005 7F000004 00000000 00000000 00000002 00000100 00000000 00000100
00000006 7F000008 00000005 00000000 7F000008 00000100 00000002 00000005
00000000 00000055 00000000 00000000 00000055 00000100 00000001 00000100
00000001 00000100 00000000 00000000 11111111 00000100 00000003 00000100
00000000 00000077 00000000 00000000 00000077 00000100 00000001 00000100
00000001 0000010C 00000000 00000000 44444444 00000100 00000001 00000100
00000003 00000200 CAFEF00D 00000000 00000200 00000100 00000001 00000100
00000001 00000200 00000000 00000000 CAFEF00D 00000100 00000001 00000100
